//--- Makefile
VERILATOR ?= verilator
TOP       ?= approx_mult_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator, run and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
+incdir+include
verilog/approx_mult_pkg.sv
verilog/leading_one_normalizer.sv
verilog/mantissa_multiplier.sv
verilog/result_scaler.sv
verilog/approx_mult_top.sv
test/approx_mult_chk.sv
test/approx_mult_tb.sv

//--- test/approx_mult_chk.sv
`timescale 1ns/1ps

module approx_mult_chk #(
    parameter int max_credits = 2
) (
    input logic                             clk,
    input logic                             reset,
    input logic                             resp_valid,
    input logic                             resp_credit,
    input logic [$clog2(max_credits+1)-1:0] credit_cnt,
    input logic                             req_valid,
    input logic                             norm_busy
);

    localparam int cw = $clog2(max_credits + 1);

    // free sink slots, followed from the port pulses alone
    int free_slots;

    always_ff @(posedge clk) begin
        if (reset) begin
            free_slots <= max_credits;
        end else begin
            free_slots <= free_slots - int'(resp_valid) + int'(resp_credit);
        end
    end

    // a response takes a free sink slot
    resp_needs_credit: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> free_slots > 0)
        else $error("resp_valid raised with no sink credit");

    credit_bounded: assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= cw'(max_credits))
        else $error("credit counter above the sink depth");

    // one slot in the normalizer, so a new request finds it idle
    req_when_idle: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> !norm_busy)
        else $error("req_valid while the normalizer is busy");

endmodule

bind result_scaler approx_mult_chk #(
    .max_credits (out_credits)
) i_scaler_chk (
    .clk         (clk),
    .reset       (reset),
    .resp_valid  (resp_valid),
    .resp_credit (resp_credit),
    .credit_cnt  (credit_cnt),
    .req_valid   (1'b0),
    .norm_busy   (1'b0)
);

bind leading_one_normalizer approx_mult_chk i_normalizer_chk (
    .clk         (clk),
    .reset       (reset),
    .resp_valid  (1'b0),
    .resp_credit (1'b0),
    .credit_cnt  ('0),
    .req_valid   (req_valid),
    .norm_busy   (state != norm_idle)
);

//--- include/approx_mult_tb_tasks.svh
`ifndef approx_mult_tb_tasks_svh
`define approx_mult_tb_tasks_svh

int          check_errors = 0;
logic [31:0] lcg_state    = 32'h57e3194f;

// numerical recipes constants
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// left shifts to bring the msb up, zero counts as none
function automatic int lead_shift(input logic [op_width-1:0] v);
    int n;
    n = 0;
    if (v != '0) begin
        while (!v[op_width-1]) begin
            v = v << 1;
            n++;
        end
    end
    return n;
endfunction

function automatic mult_resp_t model_mult(input mult_req_t r);
    int                    sa;
    int                    sb;
    logic [op_width-1:0]   na;
    logic [op_width-1:0]   nb;
    logic [prod_width-1:0] p;
    mult_resp_t            rsp;
    sa = lead_shift(r.a);
    sb = lead_shift(r.b);
    na = r.a << sa;
    nb = r.b << sb;
    p  = na[op_width-1 -: mant_width] * nb[op_width-1 -: mant_width];
    rsp.tag = r.tag;
    if (r.a == '0 || r.b == '0) begin
        rsp.result = '0;
    end else if (sa + sb <= op_width) begin
        rsp.result = res_width'(p) << (op_width - sa - sb);
    end else begin
        rsp.result = res_width'(p >> (sa + sb - op_width));
    end
    return rsp;
endfunction

task automatic check_resp(input mult_resp_t got, input mult_resp_t exp);
    if (got.result !== exp.result) begin
        $display("FAIL resp.result got %h expected %h", got.result, exp.result);
        check_errors++;
    end
    if (got.tag !== exp.tag) begin
        $display("FAIL resp.tag got %h expected %h", got.tag, exp.tag);
        check_errors++;
    end
endtask

task automatic check_credit_count(input int got, input int exp);
    if (got != exp) begin
        $display("FAIL credit_cnt got %h expected %h", got, exp);
        check_errors++;
    end
endtask

`endif

//--- test/approx_mult_tb.sv
`timescale 1ns/1ps

module approx_mult_tb
    import approx_mult_pkg::*;
();

    localparam int out_credits = 2;

    logic       clk = 1'b0;
    logic       reset;
    logic       req_valid;
    mult_req_t  req;
    logic       req_credit;
    logic       resp_valid;
    mult_resp_t resp;
    logic       resp_credit = 1'b0;

    `include "approx_mult_tb_tasks.svh"

    mult_resp_t           exp_q[$];
    int                   req_cyc_q[$];
    int                   gap_q[64];
    int                   cyc = 0;
    int                   credits_rcvd = 0;
    int                   credits_used = 0;
    int                   resp_count = 0;
    int                   sink_freed = 0;
    int                   gap_left = 0;
    int                   last_latency = 0;
    int                   test_errors = 0;
    int                   mon_errors = 0;
    logic                 sink_hold = 1'b0;
    logic                 use_gaps = 1'b0;
    logic [tag_width-1:0] next_tag = 4'h5;

    approx_mult_top #(.out_credits(out_credits)) i_dut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    // request edges, returned credits and responses, seen as the DUT saw them
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (!reset) begin
            if (req_valid) req_cyc_q.push_back(cyc);
            if (req_credit) credits_rcvd++;
            if (resp_valid) begin
                if (resp_count >= exp_q.size()) begin
                    $display("response arrived with no request outstanding");
                    mon_errors++;
                end else begin
                    check_resp(resp, exp_q[resp_count]);
                    last_latency = cyc - req_cyc_q[resp_count];
                end
                resp_count++;
            end
        end
    end

    // sink frees one slot per pulse, optionally after a random gap
    always @(posedge clk) begin
        #1;
        resp_credit = 1'b0;
        if (gap_left > 0) begin
            gap_left--;
        end else if (!reset && !sink_hold && resp_count > sink_freed) begin
            resp_credit = 1'b1;
            sink_freed++;
            if (use_gaps) gap_left = gap_q[sink_freed % 64];
        end
    end

    task automatic send_req(input logic [op_width-1:0] a, input logic [op_width-1:0] b);
        int t;
        t = 0;
        // one credit at reset, then one per returned pulse
        while (credits_used > credits_rcvd && t < 100) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (credits_used > credits_rcvd) begin
            $display("no request credit returned within %0d cycles", t);
            test_errors++;
        end else begin
            req       = '{a, b, next_tag};
            req_valid = 1'b1;
            exp_q.push_back(model_mult(req));
            credits_used++;
            next_tag++;
            @(posedge clk);
            #1;
            req_valid = 1'b0;
        end
    endtask

    task automatic wait_responses(input int n, input int limit);
        int t;
        t = 0;
        while (resp_count < n && t < limit) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (resp_count < n) begin
            $display("timed out with %0d of %0d responses", resp_count, n);
            test_errors++;
        end
    endtask

    task automatic wait_sink_idle();
        int t;
        t = 0;
        while (sink_freed != resp_count && t < 200) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (sink_freed != resp_count) begin
            $display("sink did not free its slots in time");
            test_errors++;
        end
        // the last pulse is counted on the next edge
        @(posedge clk);
        #1;
    endtask

    task automatic reset_and_first_request();
        for (int i = 0; i < 5; i++) begin
            if (req_credit !== 1'b0 || resp_valid !== 1'b0) begin
                $display("req_credit or resp_valid raised after reset with nothing sent");
                test_errors++;
            end
            @(posedge clk);
            #1;
        end
        check_credit_count(int'(i_dut.i_scaler.credit_cnt), out_credits);
        send_req(16'h1234, 16'h0567);
        wait_responses(1, 50);
    endtask

    task automatic edge_operands();
        logic [op_width-1:0] a_ops[7] = '{16'h8000, 16'hffff, 16'h0001, 16'h0005,
                                          16'h0000, 16'habcd, 16'h00ff};
        logic [op_width-1:0] b_ops[7] = '{16'hc001, 16'hffff, 16'h0003, 16'h0100,
                                          16'h1234, 16'h0000, 16'h0010};
        int base;
        base = resp_count;
        for (int i = 0; i < 7; i++) send_req(a_ops[i], b_ops[i]);
        wait_responses(base + 7, 300);
    endtask

    task automatic latency_per_shift();
        logic [op_width-1:0] a_ops[4] = '{16'h8000, 16'h0400, 16'h0001, 16'h0000};
        logic [op_width-1:0] b_ops[4] = '{16'hffff, 16'h8000, 16'h0003, 16'h0001};
        int sa;
        int sb;
        int exp_lat;
        for (int i = 0; i < 4; i++) begin
            sa      = lead_shift(a_ops[i]);
            sb      = lead_shift(b_ops[i]);
            exp_lat = 4 + (sa > sb ? sa : sb);
            send_req(a_ops[i], b_ops[i]);
            wait_responses(credits_used, 60);
            if (last_latency != exp_lat) begin
                $display("FAIL resp_valid latency got %h expected %h", last_latency, exp_lat);
                test_errors++;
            end
        end
    endtask

    task automatic credit_backpressure();
        int base;
        wait_sink_idle();
        base      = resp_count;
        sink_hold = 1'b1;
        // two leave, then one item waits in each stage
        for (int i = 0; i < 5; i++) send_req(16'h0123 << i, 16'h4321 >> i);
        repeat (30) @(posedge clk);
        #1;
        if (resp_count - base != out_credits) begin
            $display("FAIL resp_valid count got %h expected %h", resp_count - base, out_credits);
            test_errors++;
        end
        check_credit_count(int'(i_dut.i_scaler.credit_cnt), 0);
        if (credits_used <= credits_rcvd) begin
            $display("request credit returned while every stage was full");
            test_errors++;
        end
        sink_hold = 1'b0;
        wait_responses(base + 5, 200);
        wait_sink_idle();
        check_credit_count(int'(i_dut.i_scaler.credit_cnt), out_credits);
    endtask

    task automatic random_stream();
        logic [31:0] r1;
        logic [31:0] r2;
        int          base;
        for (int i = 0; i < 64; i++) gap_q[i] = int'(lcg_next() % 32'd4);
        use_gaps = 1'b1;
        base     = resp_count;
        for (int i = 0; i < 200; i++) begin
            r1 = lcg_next();
            r2 = lcg_next();
            // right shift spreads the leading one over all positions
            send_req(r1[31:16] >> r1[3:0], r2[31:16] >> r2[3:0]);
        end
        wait_responses(base + 200, 2000);
        use_gaps = 1'b0;
        wait_sink_idle();
        check_credit_count(int'(i_dut.i_scaler.credit_cnt), out_credits);
    endtask

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        reset_and_first_request();
        edge_operands();
        latency_per_shift();
        credit_backpressure();
        random_stream();
        $display("errors: %0d compare, %0d test, %0d monitor",
                 check_errors, test_errors, mon_errors);
        if (check_errors + test_errors + mon_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- verilog/approx_mult_pkg.sv
package approx_mult_pkg;

    localparam int op_width   = 16;
    localparam int mant_width = 8;
    localparam int tag_width  = 4;

    // a 16-bit operand needs at most 15 shifts
    localparam int cnt_width  = 4;
    localparam int sum_width  = cnt_width + 1;
    localparam int prod_width = 2 * mant_width;
    localparam int res_width  = 2 * op_width;

    typedef struct packed {
        logic [op_width-1:0]  a;
        logic [op_width-1:0]  b;
        logic [tag_width-1:0] tag;
    } mult_req_t;

    typedef struct packed {
        logic [mant_width-1:0] mant_a;
        logic [mant_width-1:0] mant_b;
        logic [sum_width-1:0]  shift_sum;
        logic                  zero;
        logic [tag_width-1:0]  tag;
    } norm_word_t;

    typedef struct packed {
        logic [prod_width-1:0] product;
        logic [sum_width-1:0]  shift_sum;
        logic                  zero;
        logic [tag_width-1:0]  tag;
    } prod_word_t;

    typedef struct packed {
        logic [res_width-1:0] result;
        logic [tag_width-1:0] tag;
    } mult_resp_t;

    typedef enum logic [1:0] {
        norm_idle,
        norm_shift,
        norm_hold
    } norm_state_e;

endpackage

//--- verilog/approx_mult_top.sv
`timescale 1ns/1ps

module approx_mult_top
    import approx_mult_pkg::*;
#(
    parameter int out_credits = 2
) (
    input  logic       clk,
    input  logic       reset,

    input  logic       req_valid,
    input  mult_req_t  req,
    output logic       req_credit,

    output logic       resp_valid,
    output mult_resp_t resp,
    input  logic       resp_credit
);

    logic       norm_valid;
    logic       norm_ready;
    norm_word_t norm_word;

    logic       prod_valid;
    logic       prod_ready;
    prod_word_t prod_word;

    // stage 1, variable latency
    leading_one_normalizer i_normalizer (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .norm_valid (norm_valid),
        .norm_word  (norm_word),
        .norm_ready (norm_ready)
    );

    mantissa_multiplier i_multiplier (
        .clk        (clk),
        .reset      (reset),
        .norm_valid (norm_valid),
        .norm_word  (norm_word),
        .norm_ready (norm_ready),
        .prod_valid (prod_valid),
        .prod_word  (prod_word),
        .prod_ready (prod_ready)
    );

    result_scaler #(
        .out_credits (out_credits)
    ) i_scaler (
        .clk         (clk),
        .reset       (reset),
        .prod_valid  (prod_valid),
        .prod_word   (prod_word),
        .prod_ready  (prod_ready),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .resp_credit (resp_credit)
    );

endmodule

//--- verilog/leading_one_normalizer.sv
`timescale 1ns/1ps

module leading_one_normalizer
    import approx_mult_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       req_valid,
    input  mult_req_t  req,
    output logic       req_credit,

    output logic       norm_valid,
    output norm_word_t norm_word,
    input  logic       norm_ready
);

    norm_state_e state;

    // index 0 holds operand a, index 1 operand b
    logic [1:0][op_width-1:0]  sh;
    logic [1:0][cnt_width-1:0] cnt;
    logic [1:0]                done;
    logic [tag_width-1:0]      tag_q;
    logic                      accept;

    // an operand stops once its msb is set, or right away when it is zero
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            done[i] = sh[i][op_width-1] | ~|sh[i];
        end
    end

    assign norm_valid = (state == norm_hold);
    assign accept     = norm_valid & norm_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= norm_idle;
            req_credit <= 1'b0;
        end else begin
            // slot is free again once the multiplier takes the word
            req_credit <= accept;

            case (state)
                norm_idle: begin
                    if (req_valid) begin
                        state <= norm_shift;
                    end
                end
                norm_shift: begin
                    if (&done) begin
                        state <= norm_hold;
                    end
                end
                norm_hold: begin
                    if (norm_ready) begin
                        state <= norm_idle;
                    end
                end
                default: begin
                    state <= norm_idle;
                end
            endcase
        end
    end

    // shift registers and counters
    always_ff @(posedge clk) begin
        if (state == norm_idle && req_valid) begin
            sh[0] <= req.a;
            sh[1] <= req.b;
            cnt   <= '0;
            tag_q <= req.tag;
        end else if (state == norm_shift) begin
            for (int i = 0; i < 2; i++) begin
                if (!done[i]) begin
                    sh[i]  <= sh[i] << 1;
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    // top bytes of the normalized operands
    assign norm_word.mant_a = sh[0][op_width-1 -: mant_width];
    assign norm_word.mant_b = sh[1][op_width-1 -: mant_width];

    assign norm_word.shift_sum = sum_width'(cnt[0]) + sum_width'(cnt[1]);

    // a zero operand never shifts, so the register still reads zero
    assign norm_word.zero = ~|sh[0] | ~|sh[1];
    assign norm_word.tag  = tag_q;

endmodule

//--- verilog/mantissa_multiplier.sv
`timescale 1ns/1ps

module mantissa_multiplier
    import approx_mult_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       norm_valid,
    input  norm_word_t norm_word,
    output logic       norm_ready,

    output logic       prod_valid,
    output prod_word_t prod_word,
    input  logic       prod_ready
);

    logic accept;

    // empty, or emptied this cycle by the scaler
    assign norm_ready = ~prod_valid | prod_ready;
    assign accept     = norm_valid & norm_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
        end else if (accept) begin
            prod_valid <= 1'b1;
        end else if (prod_ready) begin
            prod_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            // 8x8 product, widened by the 16-bit target
            prod_word.product   <= norm_word.mant_a * norm_word.mant_b;
            prod_word.shift_sum <= norm_word.shift_sum;
            prod_word.zero      <= norm_word.zero;
            prod_word.tag       <= norm_word.tag;
        end
    end

endmodule

//--- verilog/result_scaler.sv
`timescale 1ns/1ps

module result_scaler
    import approx_mult_pkg::*;
#(
    parameter int out_credits = 2
) (
    input  logic       clk,
    input  logic       reset,

    input  logic       prod_valid,
    input  prod_word_t prod_word,
    output logic       prod_ready,

    output logic       resp_valid,
    output mult_resp_t resp,
    input  logic       resp_credit
);

    localparam int credit_width = $clog2(out_credits + 1);

    logic [credit_width-1:0] credit_cnt;
    logic                    pending;
    logic                    load;
    logic [sum_width-1:0]    left_amt;
    logic [sum_width-1:0]    right_amt;
    logic [res_width-1:0]    scaled;

    // distance of the combined shift from the 16-bit mantissa weight
    assign left_amt  = sum_width'(op_width) - prod_word.shift_sum;
    assign right_amt = prod_word.shift_sum - sum_width'(op_width);

    always_comb begin
        if (prod_word.zero) begin
            scaled = '0;
        end else if (prod_word.shift_sum <= sum_width'(op_width)) begin
            scaled = res_width'(prod_word.product) << left_amt;
        end else begin
            // small operands, low product bits fall off
            scaled = res_width'(prod_word.product >> right_amt);
        end
    end

    // held response goes out only with a free sink slot
    assign resp_valid = pending & (credit_cnt != '0);
    assign prod_ready = ~pending | resp_valid;
    assign load       = prod_valid & prod_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending    <= 1'b0;
            credit_cnt <= credit_width'(out_credits);
        end else begin
            if (load) begin
                pending <= 1'b1;
            end else if (resp_valid) begin
                pending <= 1'b0;
            end

            case ({resp_valid, resp_credit})
                2'b10: begin
                    credit_cnt <= credit_cnt - 1'b1;
                end
                2'b01: begin
                    credit_cnt <= credit_cnt + 1'b1;
                end
                default: begin
                    credit_cnt <= credit_cnt;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            resp.result <= scaled;
            resp.tag    <= prod_word.tag;
        end
    end

endmodule
